// File: src/rv_types_pkg.sv
// Datapath widths and types

package rv_types_pkg;

  // register data, immediates and pc
  localparam int XLEN = 64;

  // instruction word
  localparam int ILEN = 32;

  // integer register count
  localparam int NUM_GPR = 32;

  // width of a register index
  localparam int GPR_AW = $clog2(NUM_GPR);

  typedef logic [XLEN-1:0] xlen_t;

  typedef logic [ILEN-1:0] inst_t;

  typedef logic [GPR_AW-1:0] gpr_addr_t;

endpackage

// File: src/rv_isa_pkg.sv
// RV64I encodings and decode controls

package rv_isa_pkg;

  // major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // funct3 of the branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [2:0] F3_LD  = 3'b011;
  localparam logic [2:0] F3_SD  = 3'b011;
  localparam logic [2:0] F3_ADD = 3'b000;  // add, addi, sub, jalr

  localparam logic [6:0] F7_ADD = 7'b0000000;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // addi x0, x0, 0
  localparam logic [31:0] INST_NOP = 32'h0000_0013;

  typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_LUI} alu_op_e;  // lui passes src2

  typedef enum logic {SRC1_RS1, SRC1_PC} src1_sel_e;

  typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_sel_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
  } br_func_e;

  typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_e;

endpackage

// File: src/id_pipe_reg.sv
// Decode stage pipeline register
`timescale 1ns/1ps

module id_pipe_reg
  import rv_types_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst_n,
  input  logic  i_load_en,         // ds allowin
  input  logic  i_fs_to_ds_valid,
  input  inst_t i_fs_inst,
  input  xlen_t i_fs_pc,
  input  logic  i_squash,          // taken branch, drop the fetched inst
  output logic  o_valid,
  output inst_t o_inst,
  output xlen_t o_pc
);

  logic accept;

  assign accept = i_load_en && i_fs_to_ds_valid;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else if (i_load_en) begin
      o_valid <= i_fs_to_ds_valid;
    end
  end

  // squashed slot keeps its pc, only the inst turns into a nop
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_inst <= INST_NOP;
      o_pc   <= '0;
    end else if (accept) begin
      o_inst <= i_squash ? INST_NOP : i_fs_inst;
      o_pc   <= i_fs_pc;
    end
  end

  // held inst must not move while the stage is blocked
  a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_valid && !i_load_en |=> $stable(o_inst) && $stable(o_pc));

endmodule

// File: src/inst_decoder.sv
// Instruction decoder
`timescale 1ns/1ps

module inst_decoder
  import rv_types_pkg::*;
  import rv_isa_pkg::*;
(
  input  inst_t     i_inst,
  output gpr_addr_t o_rs1,
  output gpr_addr_t o_rs2,
  output gpr_addr_t o_rd,
  output xlen_t     o_imm,
  output alu_op_e   o_alu_op,
  output src1_sel_e o_src1_sel,
  output src2_sel_e o_src2_sel,
  output br_func_e  o_br_func,
  output mem_op_e   o_mem_op,
  output logic      o_gpr_wen,
  output logic      o_load_sel,
  output logic      o_invalid_inst
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_rd   = i_inst[11:7];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];

  // sign-extended immediates
  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    o_imm          = '0;
    o_alu_op       = ALU_ADD;
    o_src1_sel     = SRC1_RS1;
    o_src2_sel     = SRC2_RS2;
    o_br_func      = BR_NONE;
    o_mem_op       = MEM_NONE;
    o_gpr_wen      = 1'b0;
    o_load_sel     = 1'b0;
    o_invalid_inst = 1'b0;
    case (opcode)
      OPC_LUI: begin
        o_imm      = imm_u;
        o_alu_op   = ALU_LUI;
        o_src2_sel = SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      OPC_AUIPC: begin
        o_imm      = imm_u;
        o_src1_sel = SRC1_PC;
        o_src2_sel = SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      OPC_JAL: begin
        o_imm      = imm_j;
        o_src1_sel = SRC1_PC;   // link = pc + 4
        o_src2_sel = SRC2_FOUR;
        o_br_func  = BR_JAL;
        o_gpr_wen  = 1'b1;
      end
      OPC_JALR: begin
        if (funct3 == F3_ADD) begin
          o_imm      = imm_i;
          o_src1_sel = SRC1_PC;
          o_src2_sel = SRC2_FOUR;
          o_br_func  = BR_JALR;
          o_gpr_wen  = 1'b1;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      OPC_BRANCH: begin
        o_imm = imm_b;
        case (funct3)
          F3_BEQ:  o_br_func = BR_EQ;
          F3_BNE:  o_br_func = BR_NE;
          F3_BLT:  o_br_func = BR_LT;
          F3_BGE:  o_br_func = BR_GE;
          F3_BLTU: o_br_func = BR_LTU;
          F3_BGEU: o_br_func = BR_GEU;
          default: o_invalid_inst = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        if (funct3 == F3_LD) begin
          o_imm      = imm_i;
          o_src2_sel = SRC2_IMM;
          o_mem_op   = MEM_LOAD;
          o_gpr_wen  = 1'b1;
          o_load_sel = 1'b1;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      OPC_STORE: begin
        if (funct3 == F3_SD) begin
          o_imm      = imm_s;
          o_src2_sel = SRC2_IMM;  // address only, store data is rs2
          o_mem_op   = MEM_STORE;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        if (funct3 == F3_ADD) begin
          o_imm      = imm_i;
          o_src2_sel = SRC2_IMM;
          o_gpr_wen  = 1'b1;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      OPC_OP: begin
        if (funct3 == F3_ADD && funct7 == F7_ADD) begin
          o_gpr_wen = 1'b1;
        end else if (funct3 == F3_ADD && funct7 == F7_SUB) begin
          o_alu_op  = ALU_SUB;
          o_gpr_wen = 1'b1;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      default: o_invalid_inst = 1'b1;
    endcase
  end

endmodule

// File: src/gpr_file.sv
// Integer register file
`timescale 1ns/1ps

module gpr_file
  import rv_types_pkg::*;
(
  input  logic      i_clk,
  input  gpr_addr_t i_raddr1,
  input  gpr_addr_t i_raddr2,
  output xlen_t     o_rdata1,
  output xlen_t     o_rdata2,
  input  logic      i_we,
  input  gpr_addr_t i_waddr,
  input  xlen_t     i_wdata
);

  xlen_t regs [NUM_GPR];

  // x0 slot is never written
  always_ff @(posedge i_clk) begin
    if (i_we && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // read is old data in the write cycle
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  // write-back must always present a real index
  a_waddr_known: assert property (@(posedge i_clk)
    i_we |-> !$isunknown(i_waddr));

endmodule

// File: src/operand_bypass.sv
// Operand forwarding and load-use detect
`timescale 1ns/1ps

module operand_bypass
  import rv_types_pkg::*;
(
  input  gpr_addr_t i_rs1,
  input  gpr_addr_t i_rs2,
  input  xlen_t     i_rf_rdata1,
  input  xlen_t     i_rf_rdata2,
  input  gpr_addr_t i_es_rd,
  input  xlen_t     i_es_result,
  input  gpr_addr_t i_ms_rd,
  input  xlen_t     i_ms_result,
  input  gpr_addr_t i_ws_rd,
  input  xlen_t     i_ws_result,
  input  logic      i_es_load_sel,
  output xlen_t     o_rs1_data,
  output xlen_t     o_rs2_data,
  output logic      o_load_stall
);

  // youngest producer wins, rd 0 never forwards
  function automatic xlen_t fwd_pick(input gpr_addr_t rs, input xlen_t rf_data);
    xlen_t data;
    if (i_es_rd != '0 && rs == i_es_rd) begin
      data = i_es_result;
    end else if (i_ms_rd != '0 && rs == i_ms_rd) begin
      data = i_ms_result;
    end else if (i_ws_rd != '0 && rs == i_ws_rd) begin
      data = i_ws_result;
    end else begin
      data = rf_data;
    end
    return data;
  endfunction

  always_comb begin
    o_rs1_data = fwd_pick(i_rs1, i_rf_rdata1);
    o_rs2_data = fwd_pick(i_rs2, i_rf_rdata2);
  end

  // es result of a load is only an address, wait one cycle
  assign o_load_stall = i_es_load_sel && (i_es_rd != '0) &&
                        ((i_es_rd == i_rs1) || (i_es_rd == i_rs2));

endmodule

// File: src/branch_unit.sv
// Branch and jump resolve
`timescale 1ns/1ps

module branch_unit
  import rv_types_pkg::*;
  import rv_isa_pkg::*;
(
  input  br_func_e i_br_func,
  input  xlen_t    i_rs1_data,
  input  xlen_t    i_rs2_data,
  input  xlen_t    i_pc,
  input  xlen_t    i_imm,
  input  xlen_t    i_fs_pc,      // pc fetch is currently on
  output logic     o_br_taken,
  output xlen_t    o_br_target
);

  logic  cond;
  xlen_t target;
  xlen_t jalr_sum;

  assign jalr_sum = i_rs1_data + i_imm;

  always_comb begin
    cond   = 1'b0;
    target = i_pc + i_imm;
    case (i_br_func)
      BR_EQ:   cond = (i_rs1_data == i_rs2_data);
      BR_NE:   cond = (i_rs1_data != i_rs2_data);
      BR_LT:   cond = ($signed(i_rs1_data) < $signed(i_rs2_data));
      BR_GE:   cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      BR_LTU:  cond = (i_rs1_data < i_rs2_data);
      BR_GEU:  cond = (i_rs1_data >= i_rs2_data);
      BR_JAL:  cond = 1'b1;
      BR_JALR: begin
        cond   = 1'b1;
        target = {jalr_sum[XLEN-1:1], 1'b0};
      end
      default: cond = 1'b0;
    endcase
  end

  // fetch already on the target means no redirect
  assign o_br_taken  = cond && (target != i_fs_pc);
  assign o_br_target = target;

endmodule

// File: src/id_stage.sv
// Instruction decode stage
`timescale 1ns/1ps

module id_stage
  import rv_types_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_fs_to_ds_valid,
  input  inst_t     i_fs_inst,
  input  xlen_t     i_fs_pc,
  output logic      o_ds_allowin,
  input  logic      i_es_allowin,
  output logic      o_ds_to_es_valid,
  output xlen_t     o_pc,
  output xlen_t     o_rs1_data,
  output xlen_t     o_rs2_data,
  output xlen_t     o_imm,
  output gpr_addr_t o_rd,
  output alu_op_e   o_alu_op,
  output src1_sel_e o_src1_sel,
  output src2_sel_e o_src2_sel,
  output logic      o_gpr_wen,
  output mem_op_e   o_mem_op,
  output logic      o_load_sel,
  output logic      o_invalid_inst,
  output logic      o_br_taken,
  output xlen_t     o_br_target,
  input  logic      i_rf_we,
  input  gpr_addr_t i_rf_waddr,
  input  xlen_t     i_rf_wdata,
  input  gpr_addr_t i_es_rd,
  input  xlen_t     i_es_result,
  input  gpr_addr_t i_ms_rd,
  input  xlen_t     i_ms_result,
  input  gpr_addr_t i_ws_rd,
  input  xlen_t     i_ws_result,
  input  logic      i_es_load_sel
);

  logic      ds_valid, ds_ready_go, load_stall, br_hit;
  inst_t     ds_inst;
  gpr_addr_t rs1, rs2;
  xlen_t     rf_rdata1, rf_rdata2;
  br_func_e  br_func;

  assign ds_ready_go      = ~load_stall;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;
  // a stale or stalled slot must not redirect fetch
  assign o_br_taken       = br_hit && o_ds_to_es_valid;

  id_pipe_reg u_pipe_reg (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_load_en        (o_ds_allowin),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_squash         (o_br_taken),
    .o_valid          (ds_valid),
    .o_inst           (ds_inst),
    .o_pc             (o_pc)
  );

  inst_decoder u_decoder (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_rd),
    .o_imm          (o_imm),
    .o_alu_op       (o_alu_op),
    .o_src1_sel     (o_src1_sel),
    .o_src2_sel     (o_src2_sel),
    .o_br_func      (br_func),
    .o_mem_op       (o_mem_op),
    .o_gpr_wen      (o_gpr_wen),
    .o_load_sel     (o_load_sel),
    .o_invalid_inst (o_invalid_inst)
  );

  gpr_file u_gprs (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2),
    .i_we     (i_rf_we),
    .i_waddr  (i_rf_waddr),
    .i_wdata  (i_rf_wdata)
  );

  operand_bypass u_bypass (
    .i_rs1         (rs1),
    .i_rs2         (rs2),
    .i_rf_rdata1   (rf_rdata1),
    .i_rf_rdata2   (rf_rdata2),
    .i_es_rd       (i_es_rd),
    .i_es_result   (i_es_result),
    .i_ms_rd       (i_ms_rd),
    .i_ms_result   (i_ms_result),
    .i_ws_rd       (i_ws_rd),
    .i_ws_result   (i_ws_result),
    .i_es_load_sel (i_es_load_sel),
    .o_rs1_data    (o_rs1_data),
    .o_rs2_data    (o_rs2_data),
    .o_load_stall  (load_stall)
  );

  branch_unit u_bru (
    .i_br_func   (br_func),
    .i_rs1_data  (o_rs1_data),
    .i_rs2_data  (o_rs2_data),
    .i_pc        (o_pc),
    .i_imm       (o_imm),
    .i_fs_pc     (i_fs_pc),
    .o_br_taken  (br_hit),
    .o_br_target (o_br_target)
  );

  // a load-stalled inst stays in decode until the load moves on
  a_stall_holds: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    ds_valid && load_stall |-> !o_ds_to_es_valid ##1 ds_valid);

endmodule

// File: sim/tb_id_stage.sv
// Decode stage testbench
`timescale 1ns/1ps

module tb_id_stage
  import rv_types_pkg::*;
  import rv_isa_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  // per-test cycle budgets summed for the watchdog
  localparam int RUN_CYCLES = 4 + 8*5 + 40 + 12 + 10 + 8*10 + 100;

  logic clk, rst_n, fs_valid, es_allowin, rf_we, es_load_sel;
  inst_t fs_inst;
  xlen_t fs_pc, rf_wdata, es_result, ms_result, ws_result;
  gpr_addr_t rf_waddr, es_rd, ms_rd, ws_rd;
  logic ds_allowin, ds_to_es_valid, gpr_wen, load_sel, invalid_inst, br_taken;
  xlen_t pc, rs1_data, rs2_data, imm, br_target;
  gpr_addr_t rd;
  alu_op_e alu_op;
  src1_sel_e src1_sel;
  src2_sel_e src2_sel;
  mem_op_e mem_op;

  // expected values and check enables
  logic chk_rst, chk_dec, chk_ops, chk_stall, chk_rel, chk_bp, chk_br;
  gpr_addr_t e_rd;
  xlen_t e_imm, e_rs1, e_rs2, e_pc, e_tgt;
  alu_op_e e_alu;
  src1_sel_e e_s1;
  src2_sel_e e_s2;
  mem_op_e e_mem;
  logic e_wen, e_ld, e_inv, e_taken;
  xlen_t gv [NUM_GPR];  // register model
  int errors, n_pass, n_fail, err_mark;

  id_stage dut (
    .i_clk(clk), .i_rst_n(rst_n), .i_fs_to_ds_valid(fs_valid), .i_fs_inst(fs_inst),
    .i_fs_pc(fs_pc), .o_ds_allowin(ds_allowin), .i_es_allowin(es_allowin),
    .o_ds_to_es_valid(ds_to_es_valid), .o_pc(pc), .o_rs1_data(rs1_data),
    .o_rs2_data(rs2_data), .o_imm(imm), .o_rd(rd), .o_alu_op(alu_op),
    .o_src1_sel(src1_sel), .o_src2_sel(src2_sel), .o_gpr_wen(gpr_wen),
    .o_mem_op(mem_op), .o_load_sel(load_sel), .o_invalid_inst(invalid_inst),
    .o_br_taken(br_taken), .o_br_target(br_target), .i_rf_we(rf_we),
    .i_rf_waddr(rf_waddr), .i_rf_wdata(rf_wdata), .i_es_rd(es_rd),
    .i_es_result(es_result), .i_ms_rd(ms_rd), .i_ms_result(ms_result),
    .i_ws_rd(ws_rd), .i_ws_result(ws_result), .i_es_load_sel(es_load_sel)
  );

  task automatic report(input string sig, input xlen_t got, input xlen_t exp);
    $display("** Error at %0t ns: %s = %0h, expected %0h", $time, sig, got, exp);
    errors++;
  endtask

  a_rst_allow: assert property (@(posedge clk) chk_rst |-> ds_allowin)
    else report("o_ds_allowin", 64'($sampled(ds_allowin)), 64'd1);
  a_rst_valid: assert property (@(posedge clk) chk_rst |-> !ds_to_es_valid)
    else report("o_ds_to_es_valid", 64'($sampled(ds_to_es_valid)), 64'd0);
  a_rd: assert property (@(posedge clk) chk_dec |-> rd == e_rd)
    else report("o_rd", 64'($sampled(rd)), 64'(e_rd));
  a_imm: assert property (@(posedge clk) chk_dec |-> imm == e_imm)
    else report("o_imm", $sampled(imm), e_imm);
  a_alu: assert property (@(posedge clk) chk_dec |-> alu_op == e_alu)
    else report("o_alu_op", 64'($sampled(alu_op)), 64'(e_alu));
  a_sel: assert property (@(posedge clk) chk_dec |-> src1_sel == e_s1 && src2_sel == e_s2)
    else report("o_src1_sel/o_src2_sel", 64'({$sampled(src1_sel), $sampled(src2_sel)}),
                64'({e_s1, e_s2}));
  a_mem: assert property (@(posedge clk) chk_dec |-> mem_op == e_mem)
    else report("o_mem_op", 64'($sampled(mem_op)), 64'(e_mem));
  a_flags: assert property (@(posedge clk)
    chk_dec |-> {gpr_wen, load_sel, invalid_inst} == {e_wen, e_ld, e_inv})
    else report("o_gpr_wen/o_load_sel/o_invalid_inst",
                64'({$sampled(gpr_wen), $sampled(load_sel), $sampled(invalid_inst)}),
                64'({e_wen, e_ld, e_inv}));
  a_rs1: assert property (@(posedge clk) chk_ops |-> rs1_data == e_rs1)
    else report("o_rs1_data", $sampled(rs1_data), e_rs1);
  a_rs2: assert property (@(posedge clk) chk_ops |-> rs2_data == e_rs2)
    else report("o_rs2_data", $sampled(rs2_data), e_rs2);
  a_stall: assert property (@(posedge clk) chk_stall |-> !ds_to_es_valid && !ds_allowin)
    else report("o_ds_to_es_valid/o_ds_allowin",
                64'({$sampled(ds_to_es_valid), $sampled(ds_allowin)}), 64'd0);
  a_release: assert property (@(posedge clk) chk_rel |-> ds_to_es_valid && ds_allowin)
    else report("o_ds_to_es_valid/o_ds_allowin",
                64'({$sampled(ds_to_es_valid), $sampled(ds_allowin)}), 64'd3);
  a_bp_flow: assert property (@(posedge clk) chk_bp |-> !ds_allowin && ds_to_es_valid)
    else begin
      $display("flow control wrong under back-pressure at %0t ns", $time);
      errors++;
    end
  a_bp_pc: assert property (@(posedge clk) chk_bp |-> pc == e_pc)
    else report("o_pc", $sampled(pc), e_pc);
  a_bp_rd: assert property (@(posedge clk) chk_bp |-> rd == e_rd)
    else report("o_rd", 64'($sampled(rd)), 64'(e_rd));
  a_tgt: assert property (@(posedge clk) chk_br |-> br_target == e_tgt)
    else report("o_br_target", $sampled(br_target), e_tgt);
  a_taken: assert property (@(posedge clk) chk_br |-> br_taken == e_taken)
    else report("o_br_taken", 64'($sampled(br_taken)), 64'(e_taken));

  function automatic inst_t enc_i(logic [11:0] im, gpr_addr_t rs1, logic [2:0] f3,
                                  gpr_addr_t rdi, logic [6:0] opc);
    return {im, rs1, f3, rdi, opc};
  endfunction

  function automatic inst_t enc_b(logic [12:0] im, gpr_addr_t rs2, gpr_addr_t rs1,
                                  logic [2:0] f3);
    return {im[12], im[10:5], rs2, rs1, f3, im[4:1], im[11], OPC_BRANCH};
  endfunction

  task automatic test_done(input string name);
    @(negedge clk);
    if (errors == err_mark) begin
      n_pass++;
      $display("%s: pass", name);
    end else begin
      n_fail++;
      $display("%s: FAIL", name);
    end
    err_mark = errors;
  endtask

  // present one instruction and return on the edge that accepts it
  task automatic issue(input inst_t inst, input xlen_t ipc);
    @(posedge clk);
    fs_valid <= 1'b1;
    fs_inst  <= inst;
    fs_pc    <= ipc;
    @(negedge clk);
    while (!ds_allowin) @(negedge clk);
    @(posedge clk);
    fs_valid <= 1'b0;
  endtask

  task automatic check_decode(input gpr_addr_t r, input xlen_t im, input alu_op_e a,
                              input src1_sel_e s1, input src2_sel_e s2, input mem_op_e m,
                              input logic w, input logic l, input logic inv);
    e_rd    <= r;
    e_imm   <= im;
    e_alu   <= a;
    e_s1    <= s1;
    e_s2    <= s2;
    e_mem   <= m;
    e_wen   <= w;
    e_ld    <= l;
    e_inv   <= inv;
    chk_dec <= 1'b1;
    @(posedge clk);
    chk_dec <= 1'b0;
  endtask

  task automatic check_ops(input xlen_t v1, input xlen_t v2);
    e_rs1   <= v1;
    e_rs2   <= v2;
    chk_ops <= 1'b1;
    @(posedge clk);
    chk_ops <= 1'b0;
  endtask

  task automatic rf_write(input gpr_addr_t a, input xlen_t d);
    @(posedge clk);
    rf_we    <= 1'b1;
    rf_waddr <= a;
    rf_wdata <= d;
    if (a != '0) gv[a] = d;
    @(posedge clk);
    rf_we <= 1'b0;
  endtask

  // branch followed by an addi that is squashed when the branch redirects
  task automatic branch_case(input inst_t inst, input xlen_t bpc, input xlen_t tgt,
                             input logic cond);
    logic tk;
    tk = cond && (tgt != bpc + 64'd4);
    issue(inst, bpc);
    fs_valid <= 1'b1;
    fs_inst  <= enc_i(12'd5, 5'd9, F3_ADD, 5'd9, OPC_OP_IMM);
    fs_pc    <= bpc + 64'd4;
    e_tgt    <= tgt;
    e_taken  <= tk;
    chk_br   <= 1'b1;
    @(posedge clk);
    fs_valid <= 1'b0;
    chk_br   <= 1'b0;
    if (tk) check_decode(5'd0, 64'd0, ALU_ADD, SRC1_RS1, SRC2_IMM, MEM_NONE, 1, 0, 0);
    else check_decode(5'd9, 64'd5, ALU_ADD, SRC1_RS1, SRC2_IMM, MEM_NONE, 1, 0, 0);
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the run did not finish in time");
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(320));
    rst_n       = 1'b0;
    fs_valid    = 1'b0;
    fs_inst     = INST_NOP;
    fs_pc       = '0;
    es_allowin  = 1'b1;
    rf_we       = 1'b0;
    rf_waddr    = '0;
    rf_wdata    = '0;
    es_load_sel = 1'b0;
    es_rd       = '0;
    ms_rd       = '0;
    ws_rd       = '0;
    es_result   = '0;
    ms_result   = '0;
    ws_result   = '0;
    {chk_rst, chk_dec, chk_ops, chk_stall, chk_rel, chk_bp, chk_br} = '0;
    errors   = 0;
    n_pass   = 0;
    n_fail   = 0;
    err_mark = 0;
    foreach (gv[i]) gv[i] = '0;
    repeat (2) @(posedge clk);
    rst_n   <= 1'b1;
    chk_rst <= 1'b1;
    @(posedge clk);
    chk_rst <= 1'b0;
    test_done("reset");

    issue(enc_i(12'hffb, 5'd4, F3_ADD, 5'd3, OPC_OP_IMM), 64'h100);
    check_decode(5'd3, -64'sd5, ALU_ADD, SRC1_RS1, SRC2_IMM, MEM_NONE, 1, 0, 0);
    issue({F7_ADD, 5'd6, 5'd5, F3_ADD, 5'd7, OPC_OP}, 64'h104);
    check_decode(5'd7, 64'd0, ALU_ADD, SRC1_RS1, SRC2_RS2, MEM_NONE, 1, 0, 0);
    issue({F7_SUB, 5'd6, 5'd5, F3_ADD, 5'd8, OPC_OP}, 64'h108);
    check_decode(5'd8, 64'd0, ALU_SUB, SRC1_RS1, SRC2_RS2, MEM_NONE, 1, 0, 0);
    issue({20'h80001, 5'd9, OPC_LUI}, 64'h10c);
    check_decode(5'd9, 64'hffff_ffff_8000_1000, ALU_LUI, SRC1_RS1, SRC2_IMM, MEM_NONE,
                 1, 0, 0);
    issue({20'h12345, 5'd10, OPC_AUIPC}, 64'h110);
    check_decode(5'd10, 64'h1234_5000, ALU_ADD, SRC1_PC, SRC2_IMM, MEM_NONE, 1, 0, 0);
    issue(enc_i(12'd16, 5'd2, F3_LD, 5'd11, OPC_LOAD), 64'h114);
    check_decode(5'd11, 64'd16, ALU_ADD, SRC1_RS1, SRC2_IMM, MEM_LOAD, 1, 1, 0);
    // rd field of the sd holds imm[4:0]
    issue({7'h7f, 5'd12, 5'd2, F3_SD, 5'b11000, OPC_STORE}, 64'h118);
    check_decode(5'd24, -64'sd8, ALU_ADD, SRC1_RS1, SRC2_IMM, MEM_STORE, 0, 0, 0);
    issue(32'hffff_ffff, 64'h11c);
    check_decode(5'd31, 64'd0, ALU_ADD, SRC1_RS1, SRC2_RS2, MEM_NONE, 0, 0, 1);
    test_done("decode");

    rf_write(5'd5, {$urandom(), $urandom()});
    rf_write(5'd6, {$urandom(), $urandom()});
    rf_write(5'd0, {$urandom(), $urandom()});  // x0 keeps zero
    issue({F7_ADD, 5'd6, 5'd5, F3_ADD, 5'd7, OPC_OP}, 64'h200);
    check_ops(gv[5], gv[6]);
    {es_rd, ms_rd, ws_rd} <= {5'd5, 5'd5, 5'd6};
    {es_result, ms_result, ws_result} <= {64'haaaa, 64'hbbbb, 64'hcccc};
    check_ops(64'haaaa, 64'hcccc);
    {es_rd, ms_rd, ws_rd} <= {5'd5, 5'd6, 5'd6};
    check_ops(64'haaaa, 64'hbbbb);
    {es_rd, ms_rd, ws_rd} <= {5'd0, 5'd0, 5'd5};
    check_ops(64'hcccc, gv[6]);
    ws_rd <= 5'd0;
    issue({F7_ADD, 5'd6, 5'd0, F3_ADD, 5'd7, OPC_OP}, 64'h204);
    check_ops(64'd0, gv[6]);
    {es_result, ms_result, ws_result} <= '0;
    test_done("regfile and forwarding");

    issue({F7_ADD, 5'd6, 5'd5, F3_ADD, 5'd7, OPC_OP}, 64'h300);
    es_load_sel <= 1'b1;
    es_rd       <= 5'd5;
    chk_stall   <= 1'b1;
    repeat (2) @(posedge clk);
    es_load_sel <= 1'b0;
    es_rd       <= 5'd0;
    chk_stall   <= 1'b0;
    chk_rel     <= 1'b1;
    @(posedge clk);
    chk_rel <= 1'b0;
    test_done("load-use stall");

    issue(enc_i(12'd1, 5'd1, F3_ADD, 5'd10, OPC_OP_IMM), 64'h400);
    es_allowin <= 1'b0;
    fs_valid   <= 1'b1;
    fs_inst    <= enc_i(12'd2, 5'd1, F3_ADD, 5'd13, OPC_OP_IMM);
    fs_pc      <= 64'h404;
    e_pc       <= 64'h400;
    e_rd       <= 5'd10;
    chk_bp     <= 1'b1;
    repeat (3) @(posedge clk);
    es_allowin <= 1'b1;
    chk_bp     <= 1'b0;
    @(posedge clk);
    fs_valid <= 1'b0;
    check_decode(5'd13, 64'd2, ALU_ADD, SRC1_RS1, SRC2_IMM, MEM_NONE, 1, 0, 0);
    test_done("back-pressure");

    rf_write(5'd5, {$urandom(), $urandom()} | 64'd1);
    rf_write(5'd6, {$urandom(), $urandom()});
    branch_case(enc_b(13'd32, 5'd6, 5'd5, F3_BEQ), 64'h500, 64'h520, gv[5] == gv[6]);
    branch_case(enc_b(13'd4, 5'd5, 5'd5, F3_BEQ), 64'h540, 64'h544, 1'b1);
    branch_case(enc_b(-13'sd16, 5'd6, 5'd5, F3_BNE), 64'h580, 64'h570, gv[5] != gv[6]);
    branch_case(enc_b(13'd64, 5'd6, 5'd5, F3_BLT), 64'h5c0, 64'h600,
                $signed(gv[5]) < $signed(gv[6]));
    branch_case(enc_b(13'd128, 5'd6, 5'd5, F3_BGEU), 64'h640, 64'h6c0, gv[5] >= gv[6]);
    branch_case({1'b0, 10'd0, 1'b1, 8'd0, 5'd1, OPC_JAL}, 64'h700, 64'hf00, 1'b1);
    branch_case(enc_i(12'd6, 5'd5, F3_ADD, 5'd1, OPC_JALR), 64'h740,
                (gv[5] + 64'd6) & ~64'd1, 1'b1);
    test_done("branches");

    $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
    if (n_fail == 0 && errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: build.f
src/rv_types_pkg.sv
src/rv_isa_pkg.sv
src/id_pipe_reg.sv
src/inst_decoder.sv
src/gpr_file.sv
src/operand_bypass.sv
src/branch_unit.sv
src/id_stage.sv
sim/tb_id_stage.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_id_stage
FILELIST  = build.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
